/* verilog/alu_pkg.sv */
package alu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int WORD_W = 32;

    ////////////////////
    // ALU operation codes
    ////////////////////

    // 5-bit operation encoding shared by decoder and lanes
    typedef enum logic [4:0] {
        ADD_SM = 5'd0,
        ADD    = 5'd1,
        SUB_SM = 5'd2,
        SUB    = 5'd3,
        AND    = 5'd4,
        OR     = 5'd5,
        XOR    = 5'd6,
        XNOR   = 5'd7,
        SLT_SM = 5'd8,
        SLTU   = 5'd9,
        SLL    = 5'd10,
        SRL    = 5'd11,
        SRA    = 5'd12,
        EQ     = 5'd13,
        NE     = 5'd14,
        LUI    = 5'd15,
        NOP    = 5'd31
    } alu_op_e;

    ////////////////////
    // Instruction layouts
    ////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One word read either as R-type or as I-type
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    // Major opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTIU = 6'h0b;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;

    // R-type funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    // XNOR takes the slot that is NOR elsewhere
    localparam logic [5:0] FN_XNOR = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

/* verilog/lane_if.sv */
interface lane_if;

    // Strobe for one issued operation
    logic valid;

    // Payload, meaningful only while valid is high
    alu_pkg::alu_op_e            op;
    logic [alu_pkg::WORD_W-1:0]  a;
    logic [alu_pkg::WORD_W-1:0]  b;

    modport issue (
        output valid,
        output op,
        output a,
        output b
    );

    modport lane (
        input valid,
        input op,
        input a,
        input b
    );

endinterface

/* verilog/op_decoder.sv */
module op_decoder #(
    parameter int lanes = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 in_valid,
    input  logic [alu_pkg::WORD_W-1:0]           instr,
    input  logic [lanes-1:0][alu_pkg::WORD_W-1:0] rs_data,
    input  logic [lanes-1:0][alu_pkg::WORD_W-1:0] rt_data,
    lane_if.issue                                issue [lanes],
    output logic                                 dec_illegal
);

    localparam int W = alu_pkg::WORD_W;

    // Operand A sources
    localparam logic [1:0] A_RS    = 2'd0;
    localparam logic [1:0] A_SHAMT = 2'd1;
    localparam logic [1:0] A_ZERO  = 2'd2;

    // Operand B sources
    localparam logic [1:0] B_RT   = 2'd0;
    localparam logic [1:0] B_SEXT = 2'd1;
    localparam logic [1:0] B_ZEXT = 2'd2;
    localparam logic [1:0] B_ZERO = 2'd3;

    alu_pkg::instr_u  ins;
    alu_pkg::alu_op_e dec_op;
    logic [1:0]       a_sel;
    logic [1:0]       b_sel;
    logic             illegal_c;
    logic [W-1:0]     shamt_ext;
    logic [W-1:0]     imm_sext;
    logic [W-1:0]     imm_zext;

    assign ins       = instr;
    assign shamt_ext = W'(ins.r.shamt);
    assign imm_sext  = W'($signed(ins.i.imm));
    assign imm_zext  = W'(ins.i.imm);

    ////////////////////
    // Shared decode
    ////////////////////

    always_comb
    begin
        dec_op    = alu_pkg::NOP;
        a_sel     = A_ZERO;
        b_sel     = B_ZERO;
        illegal_c = 1'b0;
        case (ins.r.opcode)
            alu_pkg::OPC_RTYPE:
            begin
                a_sel = A_RS;
                b_sel = B_RT;
                case (ins.r.funct)
                    alu_pkg::FN_SLL:
                    begin
                        dec_op = alu_pkg::SLL;
                        a_sel  = A_SHAMT;
                    end
                    alu_pkg::FN_SRL:
                    begin
                        dec_op = alu_pkg::SRL;
                        a_sel  = A_SHAMT;
                    end
                    alu_pkg::FN_SRA:
                    begin
                        dec_op = alu_pkg::SRA;
                        a_sel  = A_SHAMT;
                    end
                    alu_pkg::FN_SLLV: dec_op = alu_pkg::SLL;
                    alu_pkg::FN_SRLV: dec_op = alu_pkg::SRL;
                    alu_pkg::FN_SRAV: dec_op = alu_pkg::SRA;
                    alu_pkg::FN_ADD:  dec_op = alu_pkg::ADD_SM;
                    alu_pkg::FN_ADDU: dec_op = alu_pkg::ADD;
                    alu_pkg::FN_SUB:  dec_op = alu_pkg::SUB_SM;
                    alu_pkg::FN_SUBU: dec_op = alu_pkg::SUB;
                    alu_pkg::FN_AND:  dec_op = alu_pkg::AND;
                    alu_pkg::FN_OR:   dec_op = alu_pkg::OR;
                    alu_pkg::FN_XOR:  dec_op = alu_pkg::XOR;
                    alu_pkg::FN_XNOR: dec_op = alu_pkg::XNOR;
                    alu_pkg::FN_SLT:  dec_op = alu_pkg::SLT_SM;
                    alu_pkg::FN_SLTU: dec_op = alu_pkg::SLTU;
                    default:
                    begin
                        // Unknown funct issues a zeroed NOP
                        a_sel     = A_ZERO;
                        b_sel     = B_ZERO;
                        illegal_c = 1'b1;
                    end
                endcase
            end
            alu_pkg::OPC_BEQ:
            begin
                dec_op = alu_pkg::EQ;
                a_sel  = A_RS;
                b_sel  = B_RT;
            end
            alu_pkg::OPC_BNE:
            begin
                dec_op = alu_pkg::NE;
                a_sel  = A_RS;
                b_sel  = B_RT;
            end
            alu_pkg::OPC_ADDIU:
            begin
                dec_op = alu_pkg::ADD;
                a_sel  = A_RS;
                b_sel  = B_SEXT;
            end
            alu_pkg::OPC_SLTIU:
            begin
                dec_op = alu_pkg::SLTU;
                a_sel  = A_RS;
                b_sel  = B_SEXT;
            end
            alu_pkg::OPC_ANDI:
            begin
                dec_op = alu_pkg::AND;
                a_sel  = A_RS;
                b_sel  = B_ZEXT;
            end
            alu_pkg::OPC_ORI:
            begin
                dec_op = alu_pkg::OR;
                a_sel  = A_RS;
                b_sel  = B_ZEXT;
            end
            alu_pkg::OPC_XORI:
            begin
                dec_op = alu_pkg::XOR;
                a_sel  = A_RS;
                b_sel  = B_ZEXT;
            end
            alu_pkg::OPC_LUI:
            begin
                dec_op = alu_pkg::LUI;
                b_sel  = B_ZEXT;
            end
            default: illegal_c = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            dec_illegal <= 1'b0;
        else
            dec_illegal <= in_valid & illegal_c;
    end

    ////////////////////
    // Per-lane operands and issue
    ////////////////////

    for (genvar i = 0; i < lanes; i++)
    begin : g_issue
        logic [W-1:0] a_c;
        logic [W-1:0] b_c;

        always_comb
        begin
            case (a_sel)
                A_RS:    a_c = rs_data[i];
                A_SHAMT: a_c = shamt_ext;
                default: a_c = '0;
            endcase
            case (b_sel)
                B_RT:    b_c = rt_data[i];
                B_SEXT:  b_c = imm_sext;
                B_ZEXT:  b_c = imm_zext;
                default: b_c = '0;
            endcase
        end

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                issue[i].valid <= 1'b0;
                issue[i].op    <= alu_pkg::NOP;
            end
            else
            begin
                issue[i].valid <= in_valid;
                issue[i].op    <= dec_op;
            end
        end

        always_ff @(posedge clk)
        begin
            issue[i].a <= a_c;
            issue[i].b <= b_c;
        end

        // Illegal marker only ever travels with a NOP on every lane
        a_illegal_nop: assert property (@(posedge clk) disable iff (reset)
            dec_illegal |-> (issue[i].valid && issue[i].op == alu_pkg::NOP));
    end

endmodule

/* verilog/alu_lane.sv */
module alu_lane (
    input  logic                       clk,
    input  logic                       reset,
    lane_if.lane                       lane,
    output logic                       res_valid,
    output logic [alu_pkg::WORD_W-1:0] res,
    output logic                       res_flag
);

    localparam int W = alu_pkg::WORD_W;

    logic [W-1:0] res_c;
    logic         flag_c;

    ////////////////////
    // Sign-magnitude helpers
    ////////////////////

    // Sign-magnitude to two's complement
    function automatic logic [W-1:0] sm_to_tc(input logic [W-1:0] x);
        if (x[W-1])
            return {x[W-1], ~x[W-2:0]} + W'(1);
        return x;
    endfunction

    // Two's complement back to sign-magnitude
    function automatic logic [W-1:0] tc_to_sm(input logic [W-1:0] x);
        if (x[W-1])
            return {x[W-1], ~(x[W-2:0] - 1'b1)};
        return x;
    endfunction

    // Negated operand in two's complement for subtract
    function automatic logic [W-1:0] sm_neg_tc(input logic [W-1:0] x);
        if (x[W-1])
            return {1'b0, x[W-2:0]};
        return ~x + W'(1);
    endfunction

    // Sign first and then magnitude
    function automatic logic sm_less(input logic [W-1:0] x, input logic [W-1:0] y);
        logic lt;
        case ({x[W-1], y[W-1]})
            2'b11:   lt = x[W-2:0] > y[W-2:0];
            2'b10:   lt = 1'b1;
            2'b01:   lt = 1'b0;
            default: lt = x < y;
        endcase
        return lt;
    endfunction

    ////////////////////
    // Operation select
    ////////////////////

    always_comb
    begin
        res_c  = '0;
        flag_c = 1'b0;
        case (lane.op)
            alu_pkg::ADD_SM: res_c = tc_to_sm(sm_to_tc(lane.a) + sm_to_tc(lane.b));
            alu_pkg::ADD:    res_c = lane.a + lane.b;
            alu_pkg::SUB_SM: res_c = tc_to_sm(sm_to_tc(lane.a) + sm_neg_tc(lane.b));
            alu_pkg::SUB:    res_c = lane.a - lane.b;
            alu_pkg::AND:    res_c = lane.a & lane.b;
            alu_pkg::OR:     res_c = lane.a | lane.b;
            alu_pkg::XOR:    res_c = lane.a ^ lane.b;
            alu_pkg::XNOR:   res_c = ~(lane.a ^ lane.b);
            alu_pkg::SLT_SM: res_c = W'(sm_less(lane.a, lane.b));
            alu_pkg::SLTU:   res_c = W'(lane.a < lane.b);
            // Counts of 32 and up clear B since the whole of A is the shift amount
            alu_pkg::SLL:    res_c = lane.b << lane.a;
            alu_pkg::SRL:    res_c = lane.b >> lane.a;
            alu_pkg::SRA:    res_c = $signed(lane.b) >>> lane.a;
            alu_pkg::EQ:     flag_c = (lane.a == lane.b);
            alu_pkg::NE:     flag_c = (lane.a != lane.b);
            alu_pkg::LUI:    res_c = lane.b << 16;
            default:
            begin
                res_c  = '0;
                flag_c = 1'b0;
            end
        endcase
    end

    ////////////////////
    // Result register
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res_valid <= 1'b0;
            res       <= '0;
            res_flag  <= 1'b0;
        end
        else
        begin
            res_valid <= lane.valid;
            // Idle cycles leave a clean zero behind
            res       <= lane.valid ? res_c : '0;
            res_flag  <= lane.valid & flag_c;
        end
    end

    // A raised flag comes only from a compare issued the cycle before
    a_flag_from_cmp: assert property (@(posedge clk) disable iff (reset)
        res_flag |-> ($past(lane.valid) &&
                      ($past(lane.op) == alu_pkg::EQ || $past(lane.op) == alu_pkg::NE)));

endmodule

/* verilog/result_merge.sv */
module result_merge #(
    parameter int lanes = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  res_valid [lanes],
    input  logic [alu_pkg::WORD_W-1:0]            res [lanes],
    input  logic                                  res_flag [lanes],
    input  logic                                  dec_illegal,
    output logic                                  out_valid,
    output logic [lanes-1:0][alu_pkg::WORD_W-1:0] result,
    output logic [lanes-1:0]                      cond,
    output logic                                  illegal
);

    // Decoder flag is one stage ahead of the lane results
    logic illegal_d;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            illegal_d <= 1'b0;
            illegal   <= 1'b0;
            out_valid <= 1'b0;
            result    <= '0;
            cond      <= '0;
        end
        else
        begin
            illegal_d <= dec_illegal;
            illegal   <= illegal_d;
            // Lanes run in lockstep so lane 0 speaks for all
            out_valid <= res_valid[0];
            if (res_valid[0])
            begin
                for (int i = 0; i < lanes; i++)
                begin
                    result[i] <= res[i];
                    cond[i]   <= res_flag[i];
                end
            end
        end
    end

    // Lockstep check across lanes
    for (genvar i = 1; i < lanes; i++)
    begin : g_lockstep
        a_lanes_aligned: assert property (@(posedge clk) disable iff (reset)
            res_valid[i] == res_valid[0]);
    end

endmodule

/* verilog/alu_cluster.sv */
module alu_cluster #(
    parameter int lanes = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  logic [alu_pkg::WORD_W-1:0]            instr,
    input  logic [lanes-1:0][alu_pkg::WORD_W-1:0] rs_data,
    input  logic [lanes-1:0][alu_pkg::WORD_W-1:0] rt_data,
    output logic                                  out_valid,
    output logic [lanes-1:0][alu_pkg::WORD_W-1:0] result,
    output logic [lanes-1:0]                      cond,
    output logic                                  illegal
);

    // One issue bus per lane
    lane_if lane_bus [lanes] ();

    logic                       dec_illegal;
    logic                       lane_valid [lanes];
    logic [alu_pkg::WORD_W-1:0] lane_res [lanes];
    logic                       lane_flag [lanes];

    op_decoder #(
        .lanes (lanes)
    ) u_decoder (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .instr       (instr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .issue       (lane_bus),
        .dec_illegal (dec_illegal)
    );

    for (genvar i = 0; i < lanes; i++)
    begin : g_lane
        alu_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .lane      (lane_bus[i]),
            .res_valid (lane_valid[i]),
            .res       (lane_res[i]),
            .res_flag  (lane_flag[i])
        );
    end

    result_merge #(
        .lanes (lanes)
    ) u_merge (
        .clk         (clk),
        .reset       (reset),
        .res_valid   (lane_valid),
        .res         (lane_res),
        .res_flag    (lane_flag),
        .dec_illegal (dec_illegal),
        .out_valid   (out_valid),
        .result      (result),
        .cond        (cond),
        .illegal     (illegal)
    );

endmodule

/* verif/alu_cluster_tb.sv */
module alu_cluster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int lanes       = 4;
    localparam int word_w      = alu_pkg::WORD_W;
    localparam int latency     = 3;
    localparam int drain_limit = 50;

    localparam logic [word_w-1:0] corner_vals [7] = '{
        32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'd31,
        32'd32, 32'd1, 32'h7fff_ffff
    };

    typedef logic [lanes-1:0][word_w-1:0] vec_t;

    // Operand mode 0 random, 1 corner values, 2 equal pairs on even lanes
    typedef struct {
        alu_pkg::instr_u ins;
        int              mode;
    } row_t;

    typedef struct {
        vec_t             result;
        logic [lanes-1:0] cond;
        logic             illegal;
        int               due;
    } expect_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic [word_w-1:0] instr;
    vec_t             rs_data;
    vec_t             rt_data;
    logic             out_valid;
    vec_t             result;
    logic [lanes-1:0] cond;
    logic             illegal;

    row_t    stim_rows [$];
    expect_t exp_q [$];
    int      cycle;

    alu_cluster #(
        .lanes (lanes)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .out_valid (out_valid),
        .result    (result),
        .cond      (cond),
        .illegal   (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////
    // Checks
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [word_w-1:0] got,
                                input logic [word_w-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic match_cond(input logic [lanes-1:0] got, input logic [lanes-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: cond got %b expected %b", $time, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic longint sm_value(input logic [word_w-1:0] x);
        longint mag;
        mag = longint'(x[word_w-2:0]);
        return x[word_w-1] ? -mag : mag;
    endfunction

    // Signed sum wrapped to 32 bits and turned back into sign and magnitude
    function automatic logic [word_w-1:0] add_sign_mag(input logic [word_w-1:0] a,
                                                      input logic [word_w-1:0] b,
                                                      input logic negate_b);
        longint           vb;
        logic [word_w-1:0] t;
        logic [word_w-1:0] m;
        vb = negate_b ? -sm_value(b) : sm_value(b);
        t  = word_w'(sm_value(a) + vb);
        if (!t[word_w-1])
            return t;
        m = -t;
        return {1'b1, m[word_w-2:0]};
    endfunction

    // Negative sign wins even for a zero magnitude
    function automatic logic less_sign_mag(input logic [word_w-1:0] a,
                                           input logic [word_w-1:0] b);
        if (a[word_w-1] != b[word_w-1])
            return a[word_w-1];
        if (a[word_w-1])
            return a[word_w-2:0] > b[word_w-2:0];
        return a[word_w-2:0] < b[word_w-2:0];
    endfunction

    function automatic logic [word_w-1:0] shl_model(input logic [word_w-1:0] x,
                                                   input logic [word_w-1:0] n);
        return (n >= word_w) ? '0 : x << n[4:0];
    endfunction

    function automatic logic [word_w-1:0] shr_model(input logic [word_w-1:0] x,
                                                   input logic [word_w-1:0] n);
        return (n >= word_w) ? '0 : x >> n[4:0];
    endfunction

    function automatic logic [word_w-1:0] sra_model(input logic [word_w-1:0] x,
                                                   input logic [word_w-1:0] n);
        if (n >= word_w)
            return {word_w{x[word_w-1]}};
        return word_w'($signed(x) >>> n[4:0]);
    endfunction

    function automatic void model_lane(input alu_pkg::instr_u ins,
                                       input logic [word_w-1:0] rs,
                                       input logic [word_w-1:0] rt,
                                       output logic [word_w-1:0] res,
                                       output logic flag,
                                       output logic ill);
        logic [word_w-1:0] sext;
        logic [word_w-1:0] zext;
        logic [word_w-1:0] sh;
        sext = {{16{ins.i.imm[15]}}, ins.i.imm};
        zext = {16'h0, ins.i.imm};
        sh   = {27'h0, ins.r.shamt};
        res  = '0;
        flag = 1'b0;
        ill  = 1'b0;
        case (ins.r.opcode)
            alu_pkg::OPC_RTYPE:
            begin
                case (ins.r.funct)
                    alu_pkg::FN_SLL:  res = shl_model(rt, sh);
                    alu_pkg::FN_SRL:  res = shr_model(rt, sh);
                    alu_pkg::FN_SRA:  res = sra_model(rt, sh);
                    alu_pkg::FN_SLLV: res = shl_model(rt, rs);
                    alu_pkg::FN_SRLV: res = shr_model(rt, rs);
                    alu_pkg::FN_SRAV: res = sra_model(rt, rs);
                    alu_pkg::FN_ADD:  res = add_sign_mag(rs, rt, 1'b0);
                    alu_pkg::FN_ADDU: res = rs + rt;
                    alu_pkg::FN_SUB:  res = add_sign_mag(rs, rt, 1'b1);
                    alu_pkg::FN_SUBU: res = rs - rt;
                    alu_pkg::FN_AND:  res = rs & rt;
                    alu_pkg::FN_OR:   res = rs | rt;
                    alu_pkg::FN_XOR:  res = rs ^ rt;
                    alu_pkg::FN_XNOR: res = ~(rs ^ rt);
                    alu_pkg::FN_SLT:  res = {31'h0, less_sign_mag(rs, rt)};
                    alu_pkg::FN_SLTU: res = {31'h0, rs < rt};
                    default:          ill = 1'b1;
                endcase
            end
            alu_pkg::OPC_BEQ:   flag = (rs == rt);
            alu_pkg::OPC_BNE:   flag = (rs != rt);
            alu_pkg::OPC_ADDIU: res = rs + sext;
            alu_pkg::OPC_SLTIU: res = {31'h0, rs < sext};
            alu_pkg::OPC_ANDI:  res = rs & zext;
            alu_pkg::OPC_ORI:   res = rs | zext;
            alu_pkg::OPC_XORI:  res = rs ^ zext;
            alu_pkg::OPC_LUI:   res = {ins.i.imm, 16'h0};
            default:            ill = 1'b1;
        endcase
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////

    function automatic alu_pkg::instr_u r_word(input logic [5:0] funct,
                                               input logic [4:0] shamt);
        alu_pkg::instr_u ins;
        ins.r.opcode = alu_pkg::OPC_RTYPE;
        ins.r.rs     = 5'($urandom);
        ins.r.rt     = 5'($urandom);
        ins.r.rd     = 5'($urandom);
        ins.r.shamt  = shamt;
        ins.r.funct  = funct;
        return ins;
    endfunction

    function automatic alu_pkg::instr_u i_word(input logic [5:0] opcode,
                                               input logic [15:0] imm);
        alu_pkg::instr_u ins;
        ins.i.opcode = opcode;
        ins.i.rs     = 5'($urandom);
        ins.i.rt     = 5'($urandom);
        ins.i.imm    = imm;
        return ins;
    endfunction

    task automatic add_row(input alu_pkg::instr_u ins, input int mode);
        row_t r;
        r.ins  = ins;
        r.mode = mode;
        stim_rows.push_back(r);
    endtask

    task automatic build_table();
        logic [5:0] plain_fn [10] = '{
            alu_pkg::FN_ADDU, alu_pkg::FN_SUBU, alu_pkg::FN_AND, alu_pkg::FN_OR,
            alu_pkg::FN_XOR, alu_pkg::FN_XNOR, alu_pkg::FN_ADD, alu_pkg::FN_SUB,
            alu_pkg::FN_SLT, alu_pkg::FN_SLTU
        };
        logic [5:0] shift_fn [3] = '{alu_pkg::FN_SLLV, alu_pkg::FN_SRLV, alu_pkg::FN_SRAV};
        foreach (plain_fn[f])
        begin
            add_row(r_word(plain_fn[f], 5'd0), 0);
            add_row(r_word(plain_fn[f], 5'd0), 1);
            add_row(r_word(plain_fn[f], 5'd0), 1);
        end
        // Immediate forms
        add_row(i_word(alu_pkg::OPC_ADDIU, 16'h8001), 1);
        add_row(i_word(alu_pkg::OPC_ADDIU, 16'h7fff), 0);
        add_row(i_word(alu_pkg::OPC_SLTIU, 16'hffff), 1);
        add_row(i_word(alu_pkg::OPC_SLTIU, 16'h0020), 1);
        add_row(i_word(alu_pkg::OPC_ANDI, 16'hf0f0), 0);
        add_row(i_word(alu_pkg::OPC_ORI, 16'h1234), 1);
        add_row(i_word(alu_pkg::OPC_XORI, 16'hffff), 0);
        add_row(i_word(alu_pkg::OPC_LUI, 16'habcd), 0);
        add_row(i_word(alu_pkg::OPC_LUI, 16'h8000), 1);
        // Shifts by shamt and by rs
        add_row(r_word(alu_pkg::FN_SLL, 5'd0), 1);
        add_row(r_word(alu_pkg::FN_SLL, 5'd1), 0);
        add_row(r_word(alu_pkg::FN_SLL, 5'd31), 1);
        add_row(r_word(alu_pkg::FN_SRL, 5'd4), 0);
        add_row(r_word(alu_pkg::FN_SRL, 5'd31), 1);
        add_row(r_word(alu_pkg::FN_SRA, 5'd7), 0);
        add_row(r_word(alu_pkg::FN_SRA, 5'd31), 1);
        foreach (shift_fn[f])
        begin
            add_row(r_word(shift_fn[f], 5'd0), 1);
            add_row(r_word(shift_fn[f], 5'd0), 1);
            add_row(r_word(shift_fn[f], 5'd0), 0);
        end
        // Compares
        add_row(i_word(alu_pkg::OPC_BEQ, 16'h0010), 2);
        add_row(i_word(alu_pkg::OPC_BEQ, 16'hfff0), 1);
        add_row(i_word(alu_pkg::OPC_BNE, 16'h0004), 2);
        add_row(i_word(alu_pkg::OPC_BNE, 16'h0008), 1);
        // Undefined encodings
        add_row(i_word(6'h08, 16'h0001), 0);
        add_row(i_word(6'h23, 16'h0010), 1);
        add_row(i_word(6'h3f, 16'hffff), 0);
        add_row(r_word(6'h01, 5'd3), 0);
        add_row(r_word(6'h18, 5'd0), 1);
        add_row(r_word(6'h3f, 5'd0), 0);
        for (int n = 0; n < 16; n++)
            add_row(r_word(plain_fn[$urandom_range(9, 0)], 5'($urandom)), 0);
    endtask

    task automatic apply_row(input row_t r, input int idx);
        expect_t          e;
        logic [word_w-1:0] res;
        logic             flag;
        logic             ill;
        @(negedge clk);
        for (int k = 0; k < lanes; k++)
        begin
            case (r.mode)
                1:
                begin
                    rs_data[k] = corner_vals[(idx + k) % 7];
                    rt_data[k] = corner_vals[(idx + 3 * k + 2) % 7];
                end
                2:
                begin
                    rs_data[k] = $urandom;
                    rt_data[k] = (k % 2 == 0) ? rs_data[k] : $urandom;
                end
                default:
                begin
                    rs_data[k] = $urandom;
                    rt_data[k] = $urandom;
                end
            endcase
            model_lane(r.ins, rs_data[k], rt_data[k], res, flag, ill);
            e.result[k] = res;
            e.cond[k]   = flag;
            e.illegal   = ill;
        end
        e.due    = cycle + latency;
        instr    = r.ins;
        in_valid = 1'b1;
        exp_q.push_back(e);
    endtask

    ////////////////////
    // Output monitor
    ////////////////////

    initial
    begin
        expect_t e;
        forever
        begin
            @(negedge clk);
            if (!reset)
            begin
                if (out_valid)
                begin
                    if (exp_q.size() == 0)
                        abort_run("out_valid pulsed with no instruction in flight");
                    e = exp_q.pop_front();
                    if (cycle != e.due)
                        abort_run($sformatf("Fail at %0t: out_valid cycle got %0d expected %0d",
                                            $time, cycle, e.due));
                    for (int k = 0; k < lanes; k++)
                        compare_word($sformatf("result[%0d]", k), result[k], e.result[k]);
                    match_cond(cond, e.cond);
                    compare_bit("illegal", illegal, e.illegal);
                end
                else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
                    abort_run("out_valid never came for an issued instruction");
                else
                    compare_bit("illegal", illegal, 1'b0);
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int seed_ret;
        int waited;
        seed_ret = $urandom(32'h408c_1b32);
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        rs_data  = '0;
        rt_data  = '0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("illegal", illegal, 1'b0);

        // Back to back with a bubble every twelve rows
        foreach (stim_rows[i])
        begin
            apply_row(stim_rows[i], i);
            if (i % 12 == 11)
            begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        instr    = '0;

        waited = 0;
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit)
                abort_run("Timed out waiting for the last results to come out");
        end
        // A few quiet cycles to catch stray out_valid pulses
        repeat (4) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src.f */
verilog/alu_pkg.sv
verilog/lane_if.sv
verilog/op_decoder.sv
verilog/alu_lane.sv
verilog/result_merge.sv
verilog/alu_cluster.sv
verif/alu_cluster_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := alu_cluster_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
